//--- build.f
src/main_bus_pkg.sv
src/bus_decoder.sv
src/byte_ram.sv
src/out_latch.sv
src/frame_irq.sv
src/cabinet_mux.sv
src/main_bus.sv
bench/main_bus_assertions.sv
bench/main_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the main bus testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module main_bus_tb -f build.f -o main_bus_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/main_bus_sim > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- bench/main_bus_tb.sv
// Testbench for the main board bus
// Random bus master with 4 clock cycles, reference model of RAM,
// vectors, latches and interrupts, plus a watchdog

module main_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_ram_ops   = 400;
    localparam int n_map_ops   = 300;
    localparam int n_latch_ops = 120;
    localparam int n_cab_ops   = 120;
    localparam int n_irq_ops   = 300;
    // Up to 4 clocks plus ROM wait states per bus cycle
    localparam int total_cycles = (n_ram_ops + n_map_ops + n_latch_ops + n_cab_ops +
                                   n_irq_ops + 48) * 8 + 16;
    localparam longint watchdog_ns = longint'(total_cycles) * 8 * 2;

    logic        clk = 1'b0;
    logic        rst, cpu_cen, rnw, vma, rom_ok, service, lvbl, dip_pause;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, rom_data, vram_dout, obj_dout;
    logic [1:0]  start_button, coin_input;
    logic [5:0]  joystick1, joystick2;
    logic [23:0] dipsw;
    logic [7:0]  cpu_din, snd_latch, st_dout;
    logic [10:0] bus_addr;
    logic [15:0] rom_addr;
    logic        bus_wait, rom_cs, vram_cs, objram_cs, snd_on, mute, flip, irq_n, firq_n;

    // Reference model
    logic [7:0]  ram_m [0:4095];
    bit          ram_ok [0:4095];
    logic [7:0]  vec_m [0:15];
    bit          vec_ok [0:15];
    bit          m_flip, m_snd_on, m_mute, m_firq_en, m_irq_en;
    logic [7:0]  m_snd;
    bit          m_irq_n, m_firq_n, m_lvbl_prev;
    int unsigned frame_cnt, irq_falls, firq_falls, vid_left;
    int          errors;

    main_bus #(.rom_aw(16)) i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s at %0d ns: got %0h, expected %0h", name, $time, got, exp);
        end
    endtask

    function automatic logic [7:0] rom_hash(input logic [15:0] ra);
        return ra[7:0] ^ {ra[12:8], ra[15:13]} ^ 8'h5A;
    endfunction

    // Cabinet byte as the board wires it
    function automatic logic [7:0] cabinet_byte(input logic [1:0] sel);
        logic [5:0] joy;
        logic [7:0] b;
        joy = (sel == 2'd1) ? joystick1 : joystick2;
        b[7:6] = 2'b11;
        b[5:4] = joy[5:4];      // Buttons
        b[3]   = joy[2];        // Down
        b[2]   = joy[3];        // Up
        b[1]   = joy[0];        // Right
        b[0]   = joy[1];        // Left
        if (sel == 2'd0) begin
            b = {3'b111, start_button, service, coin_input};
        end else if (sel == 2'd3) begin
            b = dipsw[15:8];
        end
        return b;
    endfunction

    // Random blank pulses and pause switch
    task automatic advance_video();
        if (vid_left == 0) begin
            lvbl = !lvbl;
            vid_left = lvbl ? $urandom_range(6, 30) : $urandom_range(2, 8);
        end else begin
            vid_left--;
        end
        if (dip_pause) begin
            if ($urandom_range(0, 199) == 0) dip_pause = 1'b0;
        end else if ($urandom_range(0, 19) == 0) begin
            dip_pause = 1'b1;
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
        advance_video();
    endtask

    task automatic randomize_inputs();
        vram_dout    = 8'($urandom());
        obj_dout     = 8'($urandom());
        start_button = 2'($urandom());
        coin_input   = 2'($urandom());
        service      = 1'($urandom());
        joystick1    = 6'($urandom());
        joystick2    = 6'($urandom());
        dipsw        = 24'($urandom());
    endtask

    task automatic expected_read(input logic [15:0] a, output logic [7:0] exp,
                                 output bit known);
        known = 1'b1;
        exp = 8'hFF;
        if (a >= 16'h6000) begin
            if (a >= 16'hFFF0 && a <= 16'hFFFD) begin
                exp = vec_m[a[3:0]];
                known = vec_ok[a[3:0]];
            end else begin
                exp = rom_hash(a - 16'h6000);
            end
        end else if (a[15:11] == 5'h08) begin
            exp = obj_dout;
        end else if (a[15:11] == 5'h09) begin
            exp = vram_dout;
        end else if (a[15:12] == 4'h5) begin
            exp = ram_m[a[11:0]];
            known = ram_ok[a[11:0]];
        end else if (a[15:9] == 7'h18) begin
            case (a[8:7])
                2'd0: exp = dipsw[7:0];
                2'd1: exp = cabinet_byte(a[1:0]);
                2'd2: exp = dipsw[23:16];
                default: begin
                    exp = vec_m[a[3:0]];
                    known = vec_ok[a[3:0]];
                end
            endcase
        end
    endtask

    task automatic check_decode(input logic [15:0] a);
        bit io, obj, vr, wram, top, win;
        logic [15:0] rom_a;
        io    = rnw ? (a[15:9] == 7'h18) : (a[15:9] == 7'h40);
        obj   = (a[15:11] == 5'h08);
        vr    = (a[15:11] == 5'h09);
        wram  = (a[15:12] == 4'h5);
        win   = (a >= 16'hFFF0) && (a <= 16'hFFFD);
        top   = rnw && (a >= 16'h6000);
        rom_a = a - 16'h6000;
        check_value("rom_cs", 32'(rom_cs), 32'(vma && top && !win));
        check_value("vram_cs", 32'(vram_cs), 32'(vma && vr));
        check_value("objram_cs", 32'(objram_cs), 32'(vma && obj));
        check_value("bus_error", 32'(st_dout[5]), 32'(vma && !(io || obj || vr || wram || top)));
        check_value("bus_addr", 32'(bus_addr), 32'(a[10:0]));
        if (vma && top && !win) check_value("rom_addr", 32'(rom_addr), 32'(rom_a));
    endtask

    task automatic model_write(input logic [15:0] a, input logic [7:0] d);
        if (a[15:12] == 4'h5) begin
            ram_m[a[11:0]] = d;
            ram_ok[a[11:0]] = 1'b1;
        end else if (a[15:9] == 7'h40) begin
            case (a[8:7])
                2'd1: begin
                    case (a[2:0])
                        3'd0: m_flip = d[0];
                        3'd1: m_snd_on = d[0];
                        3'd2: m_mute = d[0];
                        3'd6: m_firq_en = d[0];
                        3'd7: m_irq_en = d[0];
                        default: ;
                    endcase
                end
                2'd2: m_snd = d;
                2'd3: begin
                    vec_m[a[3:0]] = d;
                    vec_ok[a[3:0]] = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_latches();
        check_value("flip", 32'(flip), 32'(m_flip));
        check_value("snd_on", 32'(snd_on), 32'(m_snd_on));
        check_value("mute", 32'(mute), 32'(m_mute));
        check_value("snd_latch", 32'(snd_latch), 32'(m_snd));
        check_value("st_dout[4:0]", 32'(st_dout[4:0]),
                    32'({m_mute, m_snd_on, m_flip, m_firq_en, m_irq_en}));
    endtask

    // One bus cycle, cpu_cen in the fourth clock or later on ROM waits
    task automatic bus_cycle(input logic [15:0] a, input bit rd, input bit valid,
                             input logic [7:0] wdata);
        logic [7:0] exp;
        bit known;
        int unsigned lat;
        int unsigned waits;
        addr = a;
        rnw = rd;
        vma = valid;
        cpu_dout = wdata;
        randomize_inputs();
        rom_data = rom_hash(a - 16'h6000);
        lat = (valid && rd && a >= 16'h6000) ? $urandom_range(0, 3) : 0;
        rom_ok = (lat == 0);
        repeat (3) next_edge();
        check_value("bus_wait", 32'(bus_wait), 32'(rom_ok));
        waits = 0;
        while (!bus_wait) begin
            next_edge();
            waits++;
            if (waits >= lat) rom_ok = 1'b1;   // ROM data ready
            if (waits > 16) begin
                errors++;
                $display("bus_wait stayed low for too long at address %h", a);
                break;
            end
        end
        cpu_cen = 1'b1;
        check_decode(a);
        if (valid && rd) begin
            expected_read(a, exp, known);
            if (known) check_value("cpu_din", 32'(cpu_din), 32'(exp));
        end
        next_edge();
        cpu_cen = 1'b0;
        if (valid && !rd) model_write(a, wdata);
        check_latches();
    endtask

    // Interrupt model, compares then steps with the inputs of the next edge
    always @(negedge clk) begin
        bit blank_start;
        bit old_irq, old_firq;
        if (rst) begin
            m_irq_n = 1'b1;
            m_firq_n = 1'b1;
            m_lvbl_prev = 1'b1;
            frame_cnt = 0;
        end else begin
            check_value("irq_n", 32'(irq_n), 32'(m_irq_n));
            check_value("firq_n", 32'(firq_n), 32'(m_firq_n));
            old_irq = m_irq_n;
            old_firq = m_firq_n;
            blank_start = !lvbl && m_lvbl_prev;
            m_lvbl_prev = lvbl;
            if (blank_start) frame_cnt++;
            if (blank_start && dip_pause && m_irq_en) begin
                m_irq_n = 1'b0;
            end else if (!m_irq_en) begin
                m_irq_n = 1'b1;
            end
            if (!m_firq_en || !dip_pause) begin
                m_firq_n = 1'b1;
            end else if (blank_start && frame_cnt[0]) begin
                m_firq_n = 1'b0;   // Odd frames only
            end
            if (old_irq && !m_irq_n) irq_falls++;
            if (old_firq && !m_firq_n) firq_falls++;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("errors: %0d", errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [15:0] a;
        logic [11:0] off;
        void'($urandom(32'h8e1f8d07));
        rst = 1'b1;
        cpu_cen = 1'b0;
        addr = '0;
        rnw = 1'b1;
        vma = 1'b0;
        cpu_dout = '0;
        rom_data = '0;
        rom_ok = 1'b1;
        start_button = '0;
        coin_input = '0;
        joystick1 = '0;
        joystick2 = '0;
        service = 1'b0;
        lvbl = 1'b1;
        dip_pause = 1'b1;
        vram_dout = '0;
        obj_dout = '0;
        dipsw = '0;
        m_snd = '0;
        vid_left = 10;
        errors = 0;
        for (int i = 0; i < 4096; i++) ram_ok[i] = 1'b0;
        for (int i = 0; i < 16; i++) vec_ok[i] = 1'b0;

        repeat (3) next_edge();
        rst = 1'b0;
        check_latches();
        check_value("irq_n", 32'(irq_n), 32'h1);
        check_value("firq_n", 32'(firq_n), 32'h1);

        // Work RAM, mostly a small window so reads hit written bytes
        for (int i = 0; i < n_ram_ops; i++) begin
            off = 12'($urandom_range(0, 63));
            if ($urandom_range(0, 3) == 0) off = 12'($urandom());
            bus_cycle({4'h5, off}, 1'($urandom()), 1'b1, 8'($urandom()));
        end

        // Whole map, with extra weight on the vector window and I/O pages
        for (int i = 0; i < n_map_ops; i++) begin
            a = 16'($urandom());
            case ($urandom_range(0, 3))
                0: a[15:4] = 12'hFFF;
                1: a[15:9] = ($urandom_range(0, 1) == 0) ? 7'h18 : 7'h40;
                default: ;
            endcase
            bus_cycle(a, 1'($urandom()), $urandom_range(0, 7) != 0, 8'($urandom()));
        end

        // Vector table
        for (int n = 0; n < 16; n++) begin
            bus_cycle(16'h8180 + 16'(n), 1'b0, 1'b1, 8'($urandom()));
        end
        for (int n = 0; n < 14; n++) begin
            bus_cycle(16'h3180 + 16'(n), 1'b1, 1'b1, 8'h00);
            bus_cycle(16'hFFF0 + 16'(n), 1'b1, 1'b1, 8'h00);
        end
        bus_cycle(16'hFFFE, 1'b1, 1'b1, 8'h00);   // Reset vector from ROM
        bus_cycle(16'hFFFF, 1'b1, 1'b1, 8'h00);

        // Output register and sound latch
        for (int i = 0; i < n_latch_ops; i++) begin
            a = ($urandom_range(0, 2) == 0) ? {9'h102, 7'($urandom())}
                                            : {9'h101, 7'($urandom())};
            bus_cycle(a, 1'b0, 1'b1, 8'($urandom()));
        end

        // Cabinet, DIP and unmapped I/O reads
        for (int i = 0; i < n_cab_ops; i++) begin
            a = ($urandom_range(0, 3) == 0) ? {4'h3, 12'($urandom())}
                                            : {7'h18, 9'($urandom())};
            bus_cycle(a, 1'b1, 1'b1, 8'h00);
        end

        // Interrupts with random enables over many frames
        bus_cycle(16'h8086, 1'b0, 1'b1, 8'h01);
        bus_cycle(16'h8087, 1'b0, 1'b1, 8'h01);
        for (int i = 0; i < n_irq_ops; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                bus_cycle({15'h4043, 1'($urandom())}, 1'b0, 1'b1,
                          {7'd0, $urandom_range(0, 9) < 7});
            end else begin
                bus_cycle(16'($urandom()), 1'b1, 1'b0, 8'h00);
            end
        end
        if (irq_falls == 0 || firq_falls == 0) begin
            errors++;
            $display("IRQ or FIRQ was never asserted during the interrupt test");
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/main_bus_assertions.sv
// Bus protocol assertions for the main board
// Bound into main_bus, watches the decoder selects and the IRQ output

module main_bus_assertions (
    input logic clk,
    input logic rst,
    input logic rnw,
    input logic rom_cs,
    input logic vram_cs,
    input logic objram_cs,
    input logic ram_cs,
    input logic vector_cs,
    input logic vector_rd,
    input logic dip1_cs,
    input logic dip3_cs,
    input logic imux_cs,
    input logic oreg_cs,
    input logic snd_cs,
    input logic irq_en,
    input logic irq_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // Regions never overlap
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, objram_cs, ram_cs, vector_cs, vector_rd,
                  dip1_cs, dip3_cs, imux_cs, oreg_cs, snd_cs}))
        else $error("more than one chip select active");

    assert property (@(posedge clk) disable iff (rst) rom_cs |-> rnw)
        else $error("ROM selected on a write");

    // Release takes one clock
    assert property (@(posedge clk) disable iff (rst) !irq_en |=> irq_n)
        else $error("IRQ asserted while disabled");

endmodule

bind main_bus main_bus_assertions u_assertions (
    .clk (clk), .rst (rst), .rnw (rnw),
    .rom_cs (rom_cs), .vram_cs (vram_cs), .objram_cs (objram_cs), .ram_cs (ram_cs),
    .vector_cs (vector_cs), .vector_rd (vector_rd), .dip1_cs (dip1_cs),
    .dip3_cs (dip3_cs), .imux_cs (imux_cs), .oreg_cs (oreg_cs), .snd_cs (snd_cs),
    .irq_en (irq_en), .irq_n (irq_n)
);

//--- src/main_bus.sv
// Main board bus glue
// Decodes the external master's cycles, holds work RAM and the vector
// table, latches outputs and returns registered read data

module main_bus #(
    parameter int rom_aw = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_cen,
    input  logic [15:0]                     addr,
    input  logic                            rnw,
    input  logic                            vma,
    input  logic [main_bus_pkg::data_w-1:0] cpu_dout,
    output logic [main_bus_pkg::data_w-1:0] cpu_din,
    output logic                            bus_wait,
    output logic [10:0]                     bus_addr,
    // ROM
    output logic [rom_aw-1:0]               rom_addr,
    output logic                            rom_cs,
    input  logic [main_bus_pkg::data_w-1:0] rom_data,
    input  logic                            rom_ok,
    // Cabinet
    input  logic [1:0]                      start_button,
    input  logic [1:0]                      coin_input,
    input  logic [5:0]                      joystick1,
    input  logic [5:0]                      joystick2,
    input  logic                            service,
    // Video
    input  logic                            lvbl,
    output logic                            vram_cs,
    output logic                            objram_cs,
    input  logic [main_bus_pkg::data_w-1:0] vram_dout,
    input  logic [main_bus_pkg::data_w-1:0] obj_dout,
    // Sound and board outputs
    output logic [main_bus_pkg::data_w-1:0] snd_latch,
    output logic                            snd_on,
    output logic                            mute,
    output logic                            flip,
    output logic                            irq_n,
    output logic                            firq_n,
    // DIP switches
    input  logic                            dip_pause,
    input  logic [23:0]                     dipsw,
    output logic [7:0]                      st_dout
);

    logic        vector_cs, vector_rd, dip1_cs, dip3_cs, imux_cs;
    logic        snd_cs, oreg_cs, ram_cs, bus_error;
    logic        wr, irq_en, firq_en;
    logic [15:0] rom_full;
    logic [main_bus_pkg::data_w-1:0] ram_dout, vec_dout, cabinet;

    assign wr       = cpu_cen && vma && !rnw;  // Write edge of the bus cycle
    assign bus_wait = rom_ok;
    assign bus_addr = addr[10:0];
    assign rom_full = addr - main_bus_pkg::rom_offset;
    assign rom_addr = rom_full[rom_aw-1:0];
    assign st_dout  = {2'b00, bus_error, mute, snd_on, flip, firq_en, irq_en};

    bus_decoder u_decoder (
        .addr      (addr),      .rnw      (rnw),       .vma       (vma),
        .io_cs     (),          .vector_cs(vector_cs), .vector_rd (vector_rd),
        .dip1_cs   (dip1_cs),   .dip3_cs  (dip3_cs),   .imux_cs   (imux_cs),
        .snd_cs    (snd_cs),    .oreg_cs  (oreg_cs),   .objram_cs (objram_cs),
        .vram_cs   (vram_cs),   .ram_cs   (ram_cs),    .rom_cs    (rom_cs),
        .bus_error (bus_error)
    );

    byte_ram #(.ram_aw(12)) u_work_ram (
        .clk (clk), .we (wr && ram_cs), .addr (addr[11:0]), .din (cpu_dout), .dout (ram_dout)
    );

    // Written on the I/O page, read there or through the vector window
    byte_ram #(.ram_aw(4)) u_vectors (
        .clk (clk), .we (wr && vector_cs), .addr (addr[3:0]), .din (cpu_dout), .dout (vec_dout)
    );

    out_latch u_out_latch (
        .clk (clk), .rst (rst), .wr (wr), .oreg_cs (oreg_cs), .snd_cs (snd_cs),
        .bit_addr (addr[2:0]), .din (cpu_dout),
        .flip (flip), .snd_on (snd_on), .mute (mute), .firq_en (firq_en),
        .irq_en (irq_en), .snd_latch (snd_latch)
    );

    frame_irq u_frame_irq (
        .clk (clk), .rst (rst), .lvbl (lvbl), .dip_pause (dip_pause),
        .irq_en (irq_en), .firq_en (firq_en), .irq_n (irq_n), .firq_n (firq_n)
    );

    cabinet_mux u_cabinet (
        .clk (clk), .sel (addr[1:0]), .start_button (start_button),
        .coin_input (coin_input), .service (service),
        .joystick1 (joystick1), .joystick2 (joystick2),
        .dipsw (dipsw[15:8]), .cabinet (cabinet)
    );

    // Read data back to the master, RAM sources arrive one clock later
    always_ff @(posedge clk) begin
        if (rom_cs)                      cpu_din <= rom_data;
        else if (vram_cs)                cpu_din <= vram_dout;
        else if (objram_cs)              cpu_din <= obj_dout;
        else if (ram_cs)                 cpu_din <= ram_dout;
        else if (dip3_cs)                cpu_din <= dipsw[23:16];
        else if (dip1_cs)                cpu_din <= dipsw[7:0];
        else if (imux_cs)                cpu_din <= cabinet;
        else if (vector_cs || vector_rd) cpu_din <= vec_dout;
        else                             cpu_din <= 8'hFF;   // Open bus
    end

endmodule

//--- src/cabinet_mux.sv
// Cabinet input multiplexer
// Picks one byte of player inputs or DIP switches and registers it,
// joystick bits are reordered to the board's wiring

module cabinet_mux (
    input  logic                            clk,
    input  logic [1:0]                      sel,
    input  logic [1:0]                      start_button,
    input  logic [1:0]                      coin_input,
    input  logic                            service,
    input  logic [5:0]                      joystick1,
    input  logic [5:0]                      joystick2,
    input  logic [main_bus_pkg::data_w-1:0] dipsw,
    output logic [main_bus_pkg::data_w-1:0] cabinet
);

    // Buttons stay in place, directions come out as down, up, right, left
    function automatic logic [main_bus_pkg::data_w-1:0] joy_byte(input logic [5:0] joy);
        joy_byte = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    logic [main_bus_pkg::data_w-1:0] sys_byte;

    assign sys_byte = {3'b111, start_button, service, coin_input};

    always_ff @(posedge clk) begin
        case (sel)
            2'd0: cabinet <= sys_byte;
            2'd1: cabinet <= joy_byte(joystick1);
            2'd2: cabinet <= joy_byte(joystick2);
            default: cabinet <= dipsw;  // Middle DIP byte
        endcase
    end

endmodule

//--- src/frame_irq.sv
// Vertical blank interrupts
// IRQ on every blank start, FIRQ on every second one, both gated by
// their enables and by the pause switch

module frame_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic dip_pause,
    input  logic irq_en,
    input  logic firq_en,
    output logic irq_n,
    output logic firq_n
);

    logic lvbl_l;
    logic blank_start;
    logic frame_odd;

    // Falling edge of lvbl
    assign blank_start = !lvbl && lvbl_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b1;
            frame_odd <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (blank_start) begin
                frame_odd <= !frame_odd;
            end
        end
    end

    // Set dominant, only a cleared enable releases it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else if (blank_start && dip_pause && irq_en) begin
            irq_n <= 1'b0;
        end else if (!irq_en) begin
            irq_n <= 1'b1;
        end
    end

    // Fires on the blank that makes the frame odd
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            firq_n <= 1'b1;
        end else if (!firq_en || !dip_pause) begin
            firq_n <= 1'b1;
        end else if (blank_start && !frame_odd) begin
            firq_n <= 1'b0;
        end
    end

endmodule

//--- src/out_latch.sv
// Output register and sound command latch
// Bit-addressable latch in the manner of a 74LS259 plus a full
// byte latch handed over to the sound board

module out_latch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wr,
    input  logic                            oreg_cs,
    input  logic                            snd_cs,
    input  logic [2:0]                      bit_addr,
    input  logic [main_bus_pkg::data_w-1:0] din,
    output logic                            flip,
    output logic                            snd_on,
    output logic                            mute,
    output logic                            firq_en,
    output logic                            irq_en,
    output logic [main_bus_pkg::data_w-1:0] snd_latch
);

    logic oreg_wr;
    logic snd_wr;

    assign oreg_wr = wr && oreg_cs;
    assign snd_wr  = wr && snd_cs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip    <= 1'b0;
            snd_on  <= 1'b0;
            mute    <= 1'b0;
            firq_en <= 1'b0;
            irq_en  <= 1'b0;
        end else if (oreg_wr) begin
            // Only D0 reaches the latch
            case (bit_addr)
                3'd0: flip    <= din[0];
                3'd1: snd_on  <= din[0];
                3'd2: mute    <= din[0];
                // 3 and 4 drive the coin counters, 5 is open
                3'd6: firq_en <= din[0];
                3'd7: irq_en  <= din[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
        end else if (snd_wr) begin
            snd_latch <= din;   // Whole command byte
        end
    end

endmodule

//--- src/byte_ram.sv
// Single-port byte RAM
// Write on we, registered read on every clock

module byte_ram #(
    parameter int ram_aw = 12
) (
    input  logic                            clk,
    input  logic                            we,
    input  logic [ram_aw-1:0]               addr,
    input  logic [main_bus_pkg::data_w-1:0] din,
    output logic [main_bus_pkg::data_w-1:0] dout
);

    localparam int depth = 2 ** ram_aw;

    logic [main_bus_pkg::data_w-1:0] mem [0:depth-1];

    // Read returns the old content during a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

endmodule

//--- src/bus_decoder.sv
// Address decoder for the main board
// Splits the CPU address into chip selects for I/O, RAM, video and ROM
// and flags accesses that hit nothing

module bus_decoder (
    input  logic [15:0] addr,
    input  logic        rnw,
    input  logic        vma,
    output logic        io_cs,
    output logic        vector_cs,
    output logic        vector_rd,
    output logic        dip1_cs,
    output logic        dip3_cs,
    output logic        imux_cs,
    output logic        snd_cs,
    output logic        oreg_cs,
    output logic        objram_cs,
    output logic        vram_cs,
    output logic        ram_cs,
    output logic        rom_cs,
    output logic        bus_error
);

    logic [1:0] io_sel;
    logic       in_window;

    assign io_sel = addr[8:7];

    // FFF0-FFFD, the last word stays in ROM
    assign in_window = (addr[15:4] == main_bus_pkg::vector_base[15:4]) && (addr[3:1] != 3'b111);

    always_comb begin
        // Reads and writes land on different pages
        io_cs = vma && (addr[15:9] == (rnw ? main_bus_pkg::io_rd_page
                                           : main_bus_pkg::io_wr_page));

        vector_cs = io_cs && (io_sel == main_bus_pkg::sel_vector); // Both directions
        dip1_cs   = io_cs &&  rnw && (io_sel == main_bus_pkg::sel_dip1);
        imux_cs   = io_cs &&  rnw && (io_sel == main_bus_pkg::sel_imux);
        dip3_cs   = io_cs &&  rnw && (io_sel == main_bus_pkg::sel_dip3);
        oreg_cs   = io_cs && !rnw && (io_sel == main_bus_pkg::sel_oreg);
        snd_cs    = io_cs && !rnw && (io_sel == main_bus_pkg::sel_snd);

        // 2 KB each for object and tile RAM, 4 KB of work RAM
        objram_cs = vma && (addr[15:11] == main_bus_pkg::objram_base[15:11]);
        vram_cs   = vma && (addr[15:11] == main_bus_pkg::vram_base[15:11]);
        ram_cs    = vma && (addr[15:12] == main_bus_pkg::ram_base[15:12]);

        // Vector fetch through the top of ROM
        vector_rd = vma && rnw && in_window;

        // ROM is read only and loses the vector window
        rom_cs = vma && rnw && (addr >= main_bus_pkg::rom_base) && !in_window;

        bus_error = vma && !(io_cs || vector_cs || vector_rd || dip1_cs || dip3_cs ||
                             imux_cs || snd_cs || oreg_cs || objram_cs || vram_cs ||
                             ram_cs || rom_cs);
    end

endmodule

//--- src/main_bus_pkg.sv
// Main-board bus address map
// Region starts, I/O page codes and sub-selects shared by the decoder
// and the top level

package main_bus_pkg;

    // Data bus
    localparam int unsigned data_w = 8;

    // I/O pages, compared against addr[15:9]
    localparam logic [6:0] io_rd_page = 7'h18;  // 3000-31FF
    localparam logic [6:0] io_wr_page = 7'h40;  // 8000-81FF

    // Read page split on addr[8:7]
    localparam logic [1:0] sel_dip1   = 2'd0;
    localparam logic [1:0] sel_imux   = 2'd1;
    localparam logic [1:0] sel_dip3   = 2'd2;
    localparam logic [1:0] sel_vector = 2'd3;   // Also used on the write page

    // Write page split on addr[8:7]
    localparam logic [1:0] sel_oreg = 2'd1;     // 74LS259 style latch
    localparam logic [1:0] sel_snd  = 2'd2;     // Sound command

    // Memory regions
    localparam logic [15:0] objram_base = 16'h4000;
    localparam logic [15:0] vram_base   = 16'h4800;
    localparam logic [15:0] ram_base    = 16'h5000;
    localparam logic [15:0] rom_base    = 16'h6000;

    // Writable vectors replace ROM from FFF0 up to FFFD
    // FFFE/FFFF (reset vector) still come from ROM
    localparam logic [15:0] vector_base = 16'hFFF0;

    // ROM image starts at CPU address 6000
    localparam logic [15:0] rom_offset = 16'h6000;

endpackage
